// ==== Bender.yml ====
package:
  name: bp

sources:
  - hdl/bp_pkg.sv
  - hdl/bht.sv
  - hdl/btb.sv
  - hdl/bp_ctrl.sv
  - hdl/bp_csr_axil.sv
  - hdl/bp_top.sv
  - target: test
    files:
      - tb/bp_tb.sv

// ==== hdl/bht.sv ====
module bht #(
	parameter int ENTRIES_NUM = 1024
) (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  bp_pkg::virt_t pc,
	input  bp_pkg::bht_update_t update,
	output bp_pkg::bht_predict_t [bp_pkg::FETCH_NUM-1:0] predict
);
	import bp_pkg::*;

	localparam int ROW_NUM = ENTRIES_NUM / FETCH_NUM;
	localparam int IDX_BITS = $clog2(ROW_NUM);

	typedef logic [IDX_BITS-1:0] idx_t;

	ctr_t ctr_q [ROW_NUM][FETCH_NUM];
	logic valid_q [ROW_NUM][FETCH_NUM];

	idx_t rd_idx;
	idx_t wr_idx;
	slot_t wr_slot;

	assign rd_idx = pc[ROW_LSB +: IDX_BITS];
	assign wr_idx = update.pc[ROW_LSB +: IDX_BITS];
	assign wr_slot = update.pc[PC_OFFSET +: SLOT_BITS];

	// Two bit saturating counter with a skip from 01 straight to 11 on taken
	function automatic ctr_t next_ctr(input ctr_t ctr, input logic taken);
		if (taken) begin
			next_ctr = (ctr == 2'b00) ? 2'b01 : 2'b11;
		end else begin
			next_ctr = (ctr == 2'b11) ? 2'b10 : 2'b00;
		end
	endfunction

	// The whole row is read out so every slot of the group gets a prediction
	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			predict[i].valid = valid_q[rd_idx][i];
			predict[i].taken = ctr_q[rd_idx][i][1]; // MSB gives the direction
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < ROW_NUM; r++) begin
				for (int s = 0; s < FETCH_NUM; s++) begin
					valid_q[r][s] <= 1'b0;
					ctr_q[r][s] <= 2'b00;
				end
			end
		end else if (flush) begin
			// Weakly taken so that one taken resolution turns the entry on
			for (int r = 0; r < ROW_NUM; r++) begin
				for (int s = 0; s < FETCH_NUM; s++) begin
					valid_q[r][s] <= 1'b0;
					ctr_q[r][s] <= 2'b10;
				end
			end
		end else if (update.valid) begin
			valid_q[wr_idx][wr_slot] <= 1'b1;
			ctr_q[wr_idx][wr_slot] <= next_ctr(ctr_q[wr_idx][wr_slot], update.taken);
		end
	end

endmodule

// ==== hdl/bp_csr_axil.sv ====
module bp_csr_axil (
	input  logic clk,
	input  logic rst,
	input  bp_pkg::axil_req_t axil_req,
	output bp_pkg::axil_rsp_t axil_rsp,
	input  bp_pkg::count_t resolved_count,
	input  bp_pkg::count_t taken_count,
	output logic flush_req
);
	import bp_pkg::*;

	logic awready, wready, bvalid, arready, rvalid;
	logic aw_held, w_held;
	logic [31:0] awaddr_q;
	logic flush_bit_q;
	logic [31:0] rdata_q;
	logic aw_hs, w_hs, ar_hs, commit;
	logic aw_held_d, w_held_d, bvalid_d, rvalid_d;

	assign aw_hs = axil_req.awvalid && awready;
	assign w_hs = axil_req.wvalid && wready;
	assign ar_hs = axil_req.arvalid && arready;
	assign commit = aw_held && w_held && !bvalid; // Both halves of the write are in

	assign aw_held_d = commit ? 1'b0 : (aw_held || aw_hs);
	assign w_held_d = commit ? 1'b0 : (w_held || w_hs);
	assign bvalid_d = commit || (bvalid && !axil_req.bready);
	assign rvalid_d = ar_hs || (rvalid && !axil_req.rready);

	always_ff @(posedge clk) begin
		if (rst) begin
			{awready, wready, bvalid, aw_held, w_held, flush_req} <= '0;
			{arready, rvalid} <= '0;
		end else begin
			aw_held <= aw_held_d;
			w_held <= w_held_d;
			bvalid <= bvalid_d;
			awready <= !aw_held_d && !bvalid_d;
			wready <= !w_held_d && !bvalid_d;
			flush_req <= commit && (awaddr_q == REG_CTRL) && flush_bit_q;
			rvalid <= rvalid_d;
			arready <= !rvalid_d; // One read outstanding at a time
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs) awaddr_q <= axil_req.awaddr;
		if (w_hs) flush_bit_q <= axil_req.wstrb[0] && axil_req.wdata[0];
		if (ar_hs) begin
			case (axil_req.araddr)
				REG_RESOLVED: rdata_q <= resolved_count;
				REG_TAKEN: rdata_q <= taken_count;
				default: rdata_q <= '0; // REG_CTRL is write only
			endcase
		end
	end

	assign axil_rsp.awready = awready;
	assign axil_rsp.wready = wready;
	assign axil_rsp.bvalid = bvalid;
	assign axil_rsp.bresp = AXI_RESP_OKAY;
	assign axil_rsp.arready = arready;
	assign axil_rsp.rvalid = rvalid;
	assign axil_rsp.rdata = rdata_q;
	assign axil_rsp.rresp = AXI_RESP_OKAY;

endmodule

// ==== hdl/bp_ctrl.sv ====
module bp_ctrl (
	input  logic clk,
	input  logic rst,
	input  bp_pkg::virt_t pc,
	input  bp_pkg::bht_predict_t [bp_pkg::FETCH_NUM-1:0] bht_pred,
	input  bp_pkg::btb_predict_t [bp_pkg::FETCH_NUM-1:0] btb_pred,
	input  bp_pkg::resolve_t resolve,
	input  logic flush_req,
	output bp_pkg::bht_update_t bht_update,
	output bp_pkg::btb_update_t btb_update,
	output logic flush,
	output bp_pkg::virt_t next_pc,
	output logic taken_slot_valid,
	output bp_pkg::count_t resolved_count,
	output bp_pkg::count_t taken_count
);
	import bp_pkg::*;

	localparam int GROUP_BYTES = FETCH_NUM * 4;
	localparam virt_t GROUP_MASK = ~virt_t'(GROUP_BYTES - 1);

	slot_t pc_slot;
	virt_t fall_through;
	logic [FETCH_NUM-1:0] slot_taken;

	assign pc_slot = pc[PC_OFFSET +: SLOT_BITS];
	assign fall_through = (pc & GROUP_MASK) + virt_t'(GROUP_BYTES);

	// A slot redirects only when the BHT says taken and the BTB has a target for it
	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			slot_taken[i] = (i >= int'(pc_slot)) && bht_pred[i].valid &&
				bht_pred[i].taken && btb_pred[i].hit;
		end
	end

	// Walking down from the top slot leaves the lowest taken slot as the winner
	always_comb begin
		taken_slot_valid = 1'b0;
		next_pc = fall_through;
		for (int i = FETCH_NUM - 1; i >= 0; i--) begin
			if (slot_taken[i]) begin
				taken_slot_valid = 1'b1;
				next_pc = btb_pred[i].target;
			end
		end
	end

	assign bht_update.valid = resolve.valid;
	assign bht_update.pc = resolve.pc;
	assign bht_update.taken = resolve.taken;

	// Not taken branches have no target worth keeping
	assign btb_update.valid = resolve.valid && resolve.taken;
	assign btb_update.pc = resolve.pc;
	assign btb_update.target = resolve.target;

	always_ff @(posedge clk) begin
		if (rst) begin
			flush <= 1'b0;
		end else begin
			flush <= flush_req;
		end
	end

	// Statistics keep running across a flush
	always_ff @(posedge clk) begin
		if (rst) begin
			resolved_count <= '0;
			taken_count <= '0;
		end else if (resolve.valid) begin
			resolved_count <= resolved_count + count_t'(1);
			if (resolve.taken) begin
				taken_count <= taken_count + count_t'(1);
			end
		end
	end

endmodule

// ==== hdl/bp_pkg.sv ====
package bp_pkg;

	localparam int FETCH_NUM = 2;
	localparam int PC_OFFSET = 2; // Word aligned instructions
	localparam int SLOT_BITS = $clog2(FETCH_NUM);
	localparam int ROW_LSB = PC_OFFSET + SLOT_BITS; // Row index starts above the slot bits

	typedef logic [31:0] virt_t;
	typedef logic [1:0] ctr_t;
	typedef logic [31:0] count_t;
	typedef logic [SLOT_BITS-1:0] slot_t;

	typedef struct packed {
		logic valid;
		logic taken;
	} bht_predict_t;

	typedef struct packed {
		logic hit;
		virt_t target;
	} btb_predict_t;

	typedef struct packed {
		logic valid;
		virt_t pc;
		logic taken;
		virt_t target;
	} resolve_t;

	typedef struct packed {
		logic valid;
		virt_t pc;
		logic taken;
	} bht_update_t;

	typedef struct packed {
		logic valid;
		virt_t pc;
		virt_t target;
	} btb_update_t;

	typedef struct packed {
		logic awvalid;
		logic [31:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		logic [31:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	localparam logic [31:0] REG_CTRL = 32'h0;
	localparam logic [31:0] REG_RESOLVED = 32'h4;
	localparam logic [31:0] REG_TAKEN = 32'h8;

endpackage

// ==== hdl/bp_top.sv ====
module bp_top #(
	parameter int BHT_ENTRIES = 1024,
	parameter int BTB_ENTRIES = 256
) (
	input  logic clk,
	input  logic rst,
	input  bp_pkg::virt_t pc,
	input  bp_pkg::resolve_t resolve,
	output bp_pkg::virt_t next_pc,
	output logic taken_slot_valid,
	input  bp_pkg::axil_req_t axil_req,
	output bp_pkg::axil_rsp_t axil_rsp
);
	import bp_pkg::*;

	bht_predict_t [FETCH_NUM-1:0] bht_pred;
	btb_predict_t [FETCH_NUM-1:0] btb_pred;
	bht_update_t bht_update;
	btb_update_t btb_update;
	logic flush, flush_req;
	count_t resolved_count, taken_count;

	bht #(.ENTRIES_NUM(BHT_ENTRIES)) bht_i (
		.clk, .rst, .flush, .pc, .update(bht_update), .predict(bht_pred)
	);

	btb #(.ENTRIES_NUM(BTB_ENTRIES)) btb_i (
		.clk, .rst, .flush, .pc, .update(btb_update), .predict(btb_pred)
	);

	bp_ctrl ctrl_i (
		.clk, .rst, .pc, .bht_pred, .btb_pred, .resolve, .flush_req, .bht_update,
		.btb_update, .flush, .next_pc, .taken_slot_valid, .resolved_count, .taken_count
	);

	bp_csr_axil csr_i (
		.clk, .rst, .axil_req, .axil_rsp, .resolved_count, .taken_count, .flush_req
	);

endmodule

// ==== hdl/btb.sv ====
module btb #(
	parameter int ENTRIES_NUM = 256
) (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  bp_pkg::virt_t pc,
	input  bp_pkg::btb_update_t update,
	output bp_pkg::btb_predict_t [bp_pkg::FETCH_NUM-1:0] predict
);
	import bp_pkg::*;

	localparam int ROW_NUM = ENTRIES_NUM / FETCH_NUM;
	localparam int IDX_BITS = $clog2(ROW_NUM);
	localparam int TAG_LSB = ROW_LSB + IDX_BITS;
	localparam int TAG_BITS = $bits(virt_t) - TAG_LSB;

	typedef logic [IDX_BITS-1:0] idx_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	logic valid_q [ROW_NUM][FETCH_NUM];
	tag_t tag_q [ROW_NUM][FETCH_NUM];
	virt_t target_q [ROW_NUM][FETCH_NUM];

	idx_t rd_idx;
	tag_t rd_tag;
	idx_t wr_idx;
	tag_t wr_tag;
	slot_t wr_slot;

	assign rd_idx = pc[ROW_LSB +: IDX_BITS];
	assign rd_tag = pc[TAG_LSB +: TAG_BITS];
	assign wr_idx = update.pc[ROW_LSB +: IDX_BITS];
	assign wr_tag = update.pc[TAG_LSB +: TAG_BITS];
	assign wr_slot = update.pc[PC_OFFSET +: SLOT_BITS];

	// All slots of a group share one tag, so the fetch pc tag is compared in every slot
	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			predict[i].hit = valid_q[rd_idx][i] && (tag_q[rd_idx][i] == rd_tag);
			predict[i].target = target_q[rd_idx][i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			for (int r = 0; r < ROW_NUM; r++) begin
				for (int s = 0; s < FETCH_NUM; s++) begin
					valid_q[r][s] <= 1'b0;
				end
			end
		end else if (update.valid) begin
			valid_q[wr_idx][wr_slot] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (update.valid) begin
			tag_q[wr_idx][wr_slot] <= wr_tag;
			target_q[wr_idx][wr_slot] <= update.target;
		end
	end

endmodule

// ==== list.f ====
hdl/bp_pkg.sv
hdl/bht.sv
hdl/btb.sv
hdl/bp_ctrl.sv
hdl/bp_csr_axil.sv
hdl/bp_top.sv
tb/bp_tb.sv

// ==== tb/bp_tb.sv ====
module bp_tb;
	import bp_pkg::*;

	localparam int BHT_ROWS = 1024 / FETCH_NUM;
	localparam int BTB_ROWS = 256 / FETCH_NUM;
	localparam int GROUP_BYTES = 4 * FETCH_NUM;
	localparam int RANDOM_OPS = 600;
	localparam int TOTAL_OPS = RANDOM_OPS + 100; // Directed steps and AXI transfers on top

	logic clk, rst;
	virt_t pc, next_pc;
	resolve_t resolve;
	logic taken_slot_valid;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;

	logic [31:0] rng_state;
	int errors;
	ctr_t m_ctr [BHT_ROWS][FETCH_NUM];
	logic m_bht_valid [BHT_ROWS][FETCH_NUM];
	logic m_btb_valid [BTB_ROWS][FETCH_NUM];
	virt_t m_btb_pc [BTB_ROWS][FETCH_NUM]; // Full branch pc, the tag is derived on compare
	virt_t m_btb_target [BTB_ROWS][FETCH_NUM];
	count_t m_resolved, m_taken;

	bp_top dut_i (.clk, .rst, .pc, .resolve, .next_pc, .taken_slot_valid, .axil_req, .axil_rsp);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (TOTAL_OPS * 20 + 200) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("Checks failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Small window so that rows alias in both tables
	function automatic virt_t random_pc();
		return 32'h0000_4000 | (next_rand() & 32'h0000_10FC);
	endfunction

	function automatic resolve_t random_resolve();
		resolve_t r;
		r.valid = (next_rand() % 4) != 0;
		r.pc = random_pc();
		r.taken = (next_rand() % 8) < 5;
		r.target = next_rand() & 32'hFFFF_FFFC;
		return r;
	endfunction

	// One row per counter value and direction
	function automatic ctr_t counter_step(input ctr_t ctr, input logic taken);
		case ({taken, ctr})
			3'b1_00: return 2'b01;
			3'b1_01: return 2'b11;
			3'b1_10: return 2'b11;
			3'b1_11: return 2'b11;
			3'b0_11: return 2'b10;
			default: return 2'b00;
		endcase
	endfunction

	task automatic check_pc(input virt_t got, input virt_t expected, input string what);
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_bit(input logic got, input logic expected, input string what);
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic check_count(input count_t got, input count_t expected, input string what);
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic model_clear(input ctr_t ctr_init);
		int r;
		int s;
		for (r = 0; r < BHT_ROWS; r++) begin
			for (s = 0; s < FETCH_NUM; s++) begin
				m_ctr[r][s] = ctr_init;
				m_bht_valid[r][s] = 1'b0;
				if (r < BTB_ROWS) m_btb_valid[r][s] = 1'b0;
			end
		end
	endtask

	task automatic model_train(input resolve_t r);
		int row;
		int slot;
		if (r.valid) begin
			row = (r.pc / GROUP_BYTES) % BHT_ROWS;
			slot = (r.pc / 4) % FETCH_NUM;
			m_resolved++;
			m_bht_valid[row][slot] = 1'b1;
			m_ctr[row][slot] = counter_step(m_ctr[row][slot], r.taken);
			if (r.taken) begin
				m_taken++;
				row = (r.pc / GROUP_BYTES) % BTB_ROWS;
				m_btb_valid[row][slot] = 1'b1;
				m_btb_pc[row][slot] = r.pc;
				m_btb_target[row][slot] = r.target;
			end
		end
	endtask

	task automatic model_predict(input virt_t fpc, output virt_t exp_pc, output logic exp_taken);
		int s;
		int bht_row;
		int btb_row;
		bht_row = (fpc / GROUP_BYTES) % BHT_ROWS;
		btb_row = (fpc / GROUP_BYTES) % BTB_ROWS;
		exp_pc = (fpc / GROUP_BYTES) * GROUP_BYTES + GROUP_BYTES;
		exp_taken = 1'b0;
		for (s = (fpc / 4) % FETCH_NUM; s < FETCH_NUM && !exp_taken; s++) begin
			if (m_bht_valid[bht_row][s] && m_ctr[bht_row][s][1] && m_btb_valid[btb_row][s] &&
				(m_btb_pc[btb_row][s] / (GROUP_BYTES * BTB_ROWS)) ==
				(fpc / (GROUP_BYTES * BTB_ROWS))) begin
				exp_pc = m_btb_target[btb_row][s];
				exp_taken = 1'b1;
			end
		end
	endtask

	// Prediction is checked before the resolution of this cycle reaches the tables
	task automatic step(input virt_t fpc, input resolve_t r);
		virt_t exp_pc;
		logic exp_taken;
		@(negedge clk);
		pc = fpc;
		resolve = r;
		model_predict(fpc, exp_pc, exp_taken);
		#1;
		check_pc(next_pc, exp_pc, "next_pc");
		check_bit(taken_slot_valid, exp_taken, "taken_slot_valid")
		;
		model_train(r);
	endtask

	// The tables still hold their state one cycle after bvalid and are clear the cycle after
	task automatic watch_flush(input virt_t fpc);
		virt_t exp_pc;
		logic exp_taken;
		int cycles;
		model_predict(fpc, exp_pc, exp_taken);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!axil_rsp.bvalid && cycles < 40);
		@(negedge clk);
		#1;
		check_pc(next_pc, exp_pc, "next_pc while flush is pending");
		check_bit(taken_slot_valid, exp_taken, "taken_slot_valid while flush is pending");
		model_clear(2'b10);
		model_predict(fpc, exp_pc, exp_taken);
		@(negedge clk);
		#1;
		check_pc(next_pc, exp_pc, "next_pc once flush applied");
		check_bit(taken_slot_valid, exp_taken, "taken_slot_valid once flush applied");
	endtask

	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
		int cycles;
		int delay;
		logic aw_acc;
		logic w_acc;
		cycles = 0;
		@(negedge clk);
		resolve = '0;
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = 4'hF;
		while ((axil_req.awvalid || axil_req.wvalid || !axil_rsp.bvalid) && cycles < 40) begin
			aw_acc = axil_req.awvalid && axil_rsp.awready;
			w_acc = axil_req.wvalid && axil_rsp.wready;
			@(negedge clk);
			if (aw_acc) axil_req.awvalid = 1'b0;
			if (w_acc) axil_req.wvalid = 1'b0;
			cycles++;
		end
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		if (!axil_rsp.bvalid) begin
			errors++;
			$display("No AXI write response arrived for address %h", addr);
		end else begin
			delay = next_rand() % 4;
			repeat (delay) begin
				@(negedge clk);
				check_bit(axil_rsp.bvalid, 1'b1, "bvalid held without bready");
			end
			check_bit(axil_rsp.bresp == AXI_RESP_OKAY, 1'b1, "bresp OKAY");
			axil_req.bready = 1'b1;
			@(negedge clk);
			axil_req.bready = 1'b0;
		end
	endtask

	task automatic axil_read(input logic [31:0] addr, input count_t expected);
		int cycles;
		int delay;
		logic ar_acc;
		count_t first;
		cycles = 0;
		@(negedge clk);
		resolve = '0;
		axil_req.arvalid = 1'b1;
		axil_req.araddr = addr;
		while ((axil_req.arvalid || !axil_rsp.rvalid) && cycles < 40) begin
			ar_acc = axil_req.arvalid && axil_rsp.arready;
			@(negedge clk);
			if (ar_acc) axil_req.arvalid = 1'b0;
			cycles++;
		end
		axil_req.arvalid = 1'b0;
		if (!axil_rsp.rvalid) begin
			errors++;
			$display("No AXI read response arrived for address %h", addr);
		end else begin
			first = axil_rsp.rdata;
			delay = next_rand() % 4;
			repeat (delay) begin
				@(negedge clk);
				check_bit(axil_rsp.rvalid, 1'b1, "rvalid held without rready");
				check_count(axil_rsp.rdata, first, "rdata held without rready");
			end
			check_count(axil_rsp.rdata, expected, "rdata");
			check_bit(axil_rsp.rresp == AXI_RESP_OKAY, 1'b1, "rresp OKAY");
			axil_req.rready = 1'b1;
			@(negedge clk);
			axil_req.rready = 1'b0;
		end
	endtask

	initial begin
		virt_t br_pc;
		resolve_t r;
		int i;
		rst = 1'b1;
		pc = '0;
		resolve = '0;
		axil_req = '0;
		rng_state = 32'd51;
		errors = 0;
		m_resolved = '0;
		m_taken = '0;
		model_clear(2'b00);
		repeat (5) @(negedge clk);
		rst = 1'b0;

		repeat (32) step(random_pc(), '0); // Untrained tables fall through everywhere

		// One branch in slot 1 walks its counter up to 11 and back down to 00
		br_pc = 32'h0000_4014;
		r = '{valid: 1'b1, pc: br_pc, taken: 1'b1, target: 32'h0000_8000};
		for (i = 0; i < 10; i++) begin
			r.taken = i < 5;
			step((i % 2 == 0) ? br_pc - 32'd4 : br_pc, r);
		end
		step(br_pc, '0);

		for (i = 0; i < RANDOM_OPS; i++) step(random_pc(), random_resolve());
		step(random_pc(), '0);

		axil_read(REG_RESOLVED, m_resolved);
		axil_read(REG_TAKEN, m_taken);
		axil_read(32'h0000_000C, '0);
		axil_read(32'h0000_0100, '0);

		// Two taken resolutions leave the branch predicted taken before the flush
		r = '{valid: 1'b1, pc: br_pc, taken: 1'b1, target: 32'h0000_8800};
		step(br_pc - 32'd4, r);
		step(br_pc - 32'd4, r);
		fork
			axil_write(REG_CTRL, 32'h1);
			watch_flush(br_pc - 32'd4);
		join
		repeat (16) step(random_pc(), '0);
		r = '{valid: 1'b1, pc: br_pc, taken: 1'b1, target: 32'h0000_9000};
		step(br_pc - 32'd4, r);
		step(br_pc - 32'd4, '0); // Counter went from 10 to 11
		axil_read(REG_RESOLVED, m_resolved);

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
